/* flist.f */
design/mem_region_pkg.sv
design/dp_ram.sv
design/instr_region.sv
design/data_region.sv
design/data_demux.sv
design/mem_region_top.sv
testbench/mem_region_sva.sv
testbench/tb_mem_region.sv

/* Bender.yml */
package:
  name: mem_region

sources:
  - design/mem_region_pkg.sv
  - design/dp_ram.sv
  - design/instr_region.sv
  - design/data_region.sv
  - design/data_demux.sv
  - design/mem_region_top.sv
  - target: test
    files:
      - testbench/mem_region_sva.sv
      - testbench/tb_mem_region.sv

/* testbench/tb_mem_region.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_region;

  localparam int MAX_CYCLES = 4000;  // Summed tests at worst external latency
  localparam int NUM_POOL   = 32;

  logic                     clk;
  logic                     rst_n;
  mem_region_pkg::mem_req_t core_req;
  mem_region_pkg::mem_rsp_t core_rsp;
  logic                     fetch_req;
  logic [31:0]              fetch_addr;
  logic                     fetch_valid;
  logic [31:0]              fetch_rdata;
  mem_region_pkg::mem_req_t ext_req;
  mem_region_pkg::mem_rsp_t ext_rsp;
  mem_region_pkg::mem_req_t load_req;
  logic [31:0]              load_rdata;
  mem_region_pkg::mem_req_t dext_req;
  logic [31:0]              dext_rdata;

  logic [31:0] instr_model [4096];
  logic [31:0] data_model [2048];
  logic [31:0] ext_model [logic [31:0]];
  logic [31:0] rng_state = 32'h36ebd535;
  int          cycle_count = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_errors_start = 0;
  int          tests_done = 0;

  mem_region_top u_mem_region_top (
    .clk                ( clk         ),
    .rst_n              ( rst_n       ),
    .core_data_req_i    ( core_req    ),
    .core_data_rsp_o    ( core_rsp    ),
    .fetch_req_i        ( fetch_req   ),
    .fetch_addr_i       ( fetch_addr  ),
    .fetch_valid_o      ( fetch_valid ),
    .fetch_rdata_o      ( fetch_rdata ),
    .ext_req_o          ( ext_req     ),
    .ext_rsp_i          ( ext_rsp     ),
    .instr_load_req_i   ( load_req    ),
    .instr_load_rdata_o ( load_rdata  ),
    .data_ext_req_i     ( dext_req    ),
    .data_ext_rdata_o   ( dext_rdata  )
  );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("run aborted, no completion after %0d cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng_state = xorshift(rng_state);
    r = rng_state;
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++)
    begin
      if (be[i])
        res[8*i +: 8] = wd[8*i +: 8];
    end
    return res;
  endfunction

  function automatic logic [10:0] pool_word(input int i);
    return 11'((i * 67 + 5) % 2048);
  endfunction

  function automatic logic [31:0] ext_addr(input int i);
    return {8'(8'h20 + i), 16'h0000, 6'(i), 2'b00};
  endfunction

  function automatic logic [31:0] ext_read_model(input logic [31:0] addr);
    if (ext_model.exists(addr))
      return ext_model[addr];
    return addr ^ 32'h6c8e9cf5;  // Contents of never written words
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    tests_done++;
    $display("%s done, %0d errors", name, errors - test_errors_start);
    test_errors_start = errors;
  endtask

  // Start of every access, inputs back to idle
  task automatic next_cycle();
    @(posedge clk);
    #2;
    core_req  = '0;
    ext_rsp   = '0;
    fetch_req = 1'b0;
    load_req  = '0;
    dext_req  = '0;
  endtask

  task automatic load_access(input logic we, input logic [11:0] w, input logic [3:0] be,
                             input logic [31:0] wd);
    next_cycle();
    load_req = '{req: 1'b1, we: we, be: be, addr: {8'h1C, 10'h0, w, 2'b00}, wdata: wd};
    @(posedge clk);
    #2;
    load_req.req = 1'b0;
    if (we)
      instr_model[w] = merge_bytes(instr_model[w], wd, be);
    else
    begin
      @(negedge clk);
      check_value("instr_load_rdata_o", load_rdata, instr_model[w]);
    end
  endtask

  task automatic fetch(input logic [31:0] addr, input logic in_region);
    next_cycle();
    fetch_req  = 1'b1;
    fetch_addr = addr;
    @(posedge clk);
    #2;
    fetch_req = 1'b0;
    @(negedge clk);
    check_value("fetch_valid_o", fetch_valid, in_region);
    if (in_region)
      check_value("fetch_rdata_o", fetch_rdata, instr_model[addr[13:2]]);
  endtask

  task automatic dext_access(input logic we, input logic [10:0] w, input logic [31:0] wd);
    next_cycle();
    dext_req = '{req: 1'b1, we: we, be: 4'hF, addr: {8'h10, 11'h0, w, 2'b00}, wdata: wd};
    @(posedge clk);
    #2;
    dext_req.req = 1'b0;
    if (we)
      data_model[w] = wd;
    else
    begin
      @(negedge clk);
      check_value("data_ext_rdata_o", dext_rdata, data_model[w]);
    end
  endtask

  task automatic check_data_ram();
    for (int i = 0; i < NUM_POOL; i++)
      dext_access(1'b0, pool_word(i), 32'h0);
  endtask

  task automatic core_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                             input logic [31:0] wd);
    logic [31:0] r;
    logic [31:0] exp;
    logic        g;
    int          waits;
    int          lat;
    next_cycle();
    core_req = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wd};
    if (addr[31:24] == 8'h10)
    begin
      @(negedge clk);
      check_value("core_data_rsp_o.gnt", core_rsp.gnt, 1'b1);
      check_value("core_data_rsp_o.rvalid", core_rsp.rvalid, 1'b0);
      check_value("ext_req_o.req", ext_req.req, 1'b0);
      @(posedge clk);
      #2;
      core_req = '0;  // Idle address decodes external
      @(negedge clk);
      check_value("core_data_rsp_o.rvalid", core_rsp.rvalid, 1'b1);
      if (we)
        data_model[addr[12:2]] = merge_bytes(data_model[addr[12:2]], wd, be);
      else
        check_value("core_data_rsp_o.rdata", core_rsp.rdata, data_model[addr[12:2]]);
    end
    else
    begin
      waits = 0;
      forever
      begin
        next_random(r);
        g = (r[1:0] != 2'b00) || (waits == 6);  // Forced grant bounds the stall
        ext_rsp.gnt = g;
        @(negedge clk);
        check_value("ext_req_o.req", ext_req.req, 1'b1);
        check_value("ext_req_o.we", ext_req.we, we);
        check_value("ext_req_o.be", ext_req.be, be);
        check_value("ext_req_o.addr", ext_req.addr, addr);
        check_value("ext_req_o.wdata", ext_req.wdata, wd);
        check_value("core_data_rsp_o.gnt", core_rsp.gnt, g);
        check_value("core_data_rsp_o.rvalid", core_rsp.rvalid, 1'b0);
        @(posedge clk);
        #2;
        if (g)
          break;
        waits++;
      end
      core_req = '0;
      core_req.addr[31:24] = 8'h10;  // Idle address decodes to RAM
      ext_rsp.gnt  = 1'b0;
      next_random(r);
      lat = 1 + (r[7:0] % 3);
      for (int i = 1; i < lat; i++)
      begin
        @(negedge clk);
        check_value("core_data_rsp_o.rvalid", core_rsp.rvalid, 1'b0);
        @(posedge clk);
        #2;
      end
      next_random(r);
      exp = we ? r : ext_read_model(addr);
      ext_rsp.rvalid = 1'b1;
      ext_rsp.rdata  = exp;
      @(negedge clk);
      check_value("core_data_rsp_o.rvalid", core_rsp.rvalid, 1'b1);
      check_value("core_data_rsp_o.rdata", core_rsp.rdata, exp);
      if (we)
        ext_model[addr] = merge_bytes(ext_read_model(addr), wd, be);
    end
  endtask

  task automatic random_ram_access();
    logic [31:0] r;
    logic [31:0] wd;
    logic [10:0] w;
    next_random(r);
    next_random(wd);
    w = pool_word(int'(r[20:16]));
    core_access(r[0], r[7:4], {8'h10, 11'h0, w, 2'b00}, wd);
  endtask

  task automatic random_ext_access();
    logic [31:0] r;
    logic [31:0] wd;
    next_random(r);
    next_random(wd);
    core_access(r[0], r[7:4], ext_addr(int'(r[19:16])), wd);
  endtask

  initial
  begin
    logic [31:0] r;
    logic [31:0] a;
    clk       = 1'b0;
    rst_n     = 1'b0;
    core_req  = '0;
    ext_rsp   = '0;
    fetch_req = 1'b0;
    fetch_addr = 32'h0;
    load_req  = '0;
    dext_req  = '0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Full word first so no byte stays unknown
    for (int i = 0; i < 64; i++)
    begin
      next_random(r);
      load_access(1'b1, 12'((i * 61 + 3) % 4096), 4'hF, r);
      next_random(r);
      load_access(1'b1, 12'((i * 61 + 3) % 4096), r[3:0], xorshift(r));
      load_access(1'b0, 12'((i * 61 + 3) % 4096), 4'h0, 32'h0);
    end
    for (int i = 0; i < 64; i++)
      fetch({8'h1C, 10'h0, 12'((i * 61 + 3) % 4096), 2'b00}, 1'b1);
    finish_test("test 1 instruction load and fetch");

    for (int i = 0; i < 16; i++)
    begin
      next_random(a);
      if (a[31:24] == 8'h1C)
        a[31:24] = 8'h1D;
      fetch(a, 1'b0);
    end
    finish_test("test 2 out-of-region fetch");

    for (int i = 0; i < NUM_POOL; i++)
    begin
      next_random(r);
      dext_access(1'b1, pool_word(i), r);
    end
    for (int i = 0; i < 100; i++)
      random_ram_access();
    finish_test("test 3 core data RAM access");

    for (int i = 0; i < 40; i++)
      random_ext_access();
    check_data_ram();
    finish_test("test 4 external routing");

    for (int i = 0; i < 120; i++)
    begin
      next_random(r);
      if (r[0])
        random_ram_access();
      else
        random_ext_access();
    end
    check_data_ram();
    finish_test("test 5 mixed traffic");

    errors += u_mem_region_top.u_mem_region_sva.fail_count;
    $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/mem_region_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_region_sva (
  input wire                       clk,
  input wire                       rst_n,
  input mem_region_pkg::mem_req_t  core_data_req_i,
  input mem_region_pkg::mem_rsp_t  core_data_rsp_o,
  input mem_region_pkg::mem_req_t  ext_req_o,
  input mem_region_pkg::mem_req_t  ram_req_i,
  input logic                      fetch_req_i,
  input logic [31:0]               fetch_addr_i,
  input logic                      fetch_valid_o
);

  int fail_count = 0;

  gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    core_data_rsp_o.gnt |-> core_data_req_i.req)
  else
  begin
    fail_count++;
    $error("core grant without a request");
  end

  one_target: assert property (@(posedge clk) disable iff (!rst_n)
    !(ext_req_o.req && ram_req_i.req))
  else
  begin
    fail_count++;
    $error("request sent to RAM and external port together");
  end

  // Valid only after an accepted fetch
  fetch_valid_origin: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid_o |->
      $past(fetch_req_i && (fetch_addr_i[31:24] == mem_region_pkg::INSTR_BASE)))
  else
  begin
    fail_count++;
    $error("fetch valid without an in-region fetch");
  end

endmodule

bind mem_region_top mem_region_sva u_mem_region_sva (
  .clk             ( clk             ),
  .rst_n           ( rst_n           ),
  .core_data_req_i ( core_data_req_i ),
  .core_data_rsp_o ( core_data_rsp_o ),
  .ext_req_o       ( ext_req_o       ),
  .ram_req_i       ( ram_req         ),
  .fetch_req_i     ( fetch_req_i     ),
  .fetch_addr_i    ( fetch_addr_i    ),
  .fetch_valid_o   ( fetch_valid_o   )
);

`default_nettype wire

/* design/mem_region_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_region_top (
  input  wire                       clk,
  input  wire                       rst_n,

  // Core data port
  input  mem_region_pkg::mem_req_t  core_data_req_i,
  output mem_region_pkg::mem_rsp_t  core_data_rsp_o,

  // Core fetch port
  input  logic                      fetch_req_i,
  input  logic [31:0]               fetch_addr_i,
  output logic                      fetch_valid_o,
  output logic [31:0]               fetch_rdata_o,

  // External bus master
  output mem_region_pkg::mem_req_t  ext_req_o,
  input  mem_region_pkg::mem_rsp_t  ext_rsp_i,

  // Slave ports from the outside
  input  mem_region_pkg::mem_req_t  instr_load_req_i,
  output logic [31:0]               instr_load_rdata_o,
  input  mem_region_pkg::mem_req_t  data_ext_req_i,
  output logic [31:0]               data_ext_rdata_o
);

  mem_region_pkg::mem_req_t ram_req;
  mem_region_pkg::mem_rsp_t ram_rsp;

  data_demux u_data_demux (
    .clk        ( clk             ),
    .rst_n      ( rst_n           ),
    .core_req_i ( core_data_req_i ),
    .core_rsp_o ( core_data_rsp_o ),
    .ram_req_o  ( ram_req         ),
    .ram_rsp_i  ( ram_rsp         ),
    .ext_req_o  ( ext_req_o       ),
    .ext_rsp_i  ( ext_rsp_i       )
  );

  data_region u_data_region (
    .clk         ( clk              ),
    .rst_n       ( rst_n            ),
    .core_req_i  ( ram_req          ),
    .core_rsp_o  ( ram_rsp          ),
    .ext_req_i   ( data_ext_req_i   ),
    .ext_rdata_o ( data_ext_rdata_o )
  );

  instr_region u_instr_region (
    .clk           ( clk                ),
    .rst_n         ( rst_n              ),
    .fetch_req_i   ( fetch_req_i        ),
    .fetch_addr_i  ( fetch_addr_i       ),
    .fetch_valid_o ( fetch_valid_o      ),
    .fetch_rdata_o ( fetch_rdata_o      ),
    .load_req_i    ( instr_load_req_i   ),
    .load_rdata_o  ( instr_load_rdata_o )
  );

endmodule

`default_nettype wire

/* design/data_demux.sv */
`timescale 1ns/1ps
`default_nettype none

module data_demux (
  input  wire                       clk,
  input  wire                       rst_n,
  input  mem_region_pkg::mem_req_t  core_req_i,
  output mem_region_pkg::mem_rsp_t  core_rsp_o,
  output mem_region_pkg::mem_req_t  ram_req_o,
  input  mem_region_pkg::mem_rsp_t  ram_rsp_i,
  output mem_region_pkg::mem_req_t  ext_req_o,
  input  mem_region_pkg::mem_rsp_t  ext_rsp_i
);

  typedef enum logic {
    TGT_RAM,
    TGT_EXT
  } target_e;

  target_e tgt_q;
  target_e tgt_d;
  logic    sel_ram;
  logic    gnt;

  assign sel_ram = (core_req_i.addr[31:24] == mem_region_pkg::DATA_BASE);

  // Same payload on both sides, only one req strobe set
  always_comb
  begin
    ram_req_o     = core_req_i;
    ext_req_o     = core_req_i;
    ram_req_o.req = core_req_i.req && sel_ram;
    ext_req_o.req = core_req_i.req && !sel_ram;
  end

  // Grant follows the address decode of the live request
  assign gnt = core_req_i.req && (sel_ram ? ram_rsp_i.gnt : ext_rsp_i.gnt);

  always_comb
  begin
    tgt_d = tgt_q;
    if (gnt)
      tgt_d = sel_ram ? TGT_RAM : TGT_EXT;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tgt_q <= TGT_RAM;
    else
      tgt_q <= tgt_d;
  end

  // Response comes from whoever took the last grant
  always_comb
  begin
    core_rsp_o.gnt = gnt;
    if (tgt_q == TGT_EXT)
    begin
      core_rsp_o.rvalid = ext_rsp_i.rvalid;
      core_rsp_o.rdata  = ext_rsp_i.rdata;
    end
    else
    begin
      core_rsp_o.rvalid = ram_rsp_i.rvalid;
      core_rsp_o.rdata  = ram_rsp_i.rdata;
    end
  end

endmodule

`default_nettype wire

/* design/data_region.sv */
`timescale 1ns/1ps
`default_nettype none

module data_region (
  input  wire                       clk,
  input  wire                       rst_n,
  input  mem_region_pkg::mem_req_t  core_req_i,
  output mem_region_pkg::mem_rsp_t  core_rsp_o,
  input  mem_region_pkg::mem_req_t  ext_req_i,
  output logic [31:0]               ext_rdata_o
);

  logic rvalid_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= core_req_i.req;  // One response per grant
  end

  // The RAM never stalls
  assign core_rsp_o.gnt    = core_req_i.req;
  assign core_rsp_o.rvalid = rvalid_q;

  dp_ram #(
    .ADDR_WIDTH ( mem_region_pkg::DATA_ADDR_WIDTH )
  ) data_mem (
    .clk       ( clk                                                  ),
    .en_a_i    ( core_req_i.req                                       ),
    .we_a_i    ( core_req_i.we                                        ),
    .be_a_i    ( core_req_i.be                                        ),
    .addr_a_i  ( core_req_i.addr[mem_region_pkg::DATA_ADDR_WIDTH+1:2] ),
    .wdata_a_i ( core_req_i.wdata                                     ),
    .rdata_a_o ( core_rsp_o.rdata                                     ),
    .en_b_i    ( ext_req_i.req                                        ),
    .we_b_i    ( ext_req_i.we                                         ),
    .be_b_i    ( ext_req_i.be                                         ),
    .addr_b_i  ( ext_req_i.addr[mem_region_pkg::DATA_ADDR_WIDTH+1:2]  ),
    .wdata_b_i ( ext_req_i.wdata                                      ),
    .rdata_b_o ( ext_rdata_o                                          )
  );

endmodule

`default_nettype wire

/* design/instr_region.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_region (
  input  wire                       clk,
  input  wire                       rst_n,
  input  logic                      fetch_req_i,
  input  logic [31:0]               fetch_addr_i,
  output logic                      fetch_valid_o,
  output logic [31:0]               fetch_rdata_o,
  input  mem_region_pkg::mem_req_t  load_req_i,
  output logic [31:0]               load_rdata_o
);

  logic fetch_en;

  // Only fetches inside the boot region reach the RAM
  assign fetch_en = fetch_req_i && (fetch_addr_i[31:24] == mem_region_pkg::INSTR_BASE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      fetch_valid_o <= 1'b0;
    else
      fetch_valid_o <= fetch_en;  // Matches RAM read latency
  end

  dp_ram #(
    .ADDR_WIDTH ( mem_region_pkg::INSTR_ADDR_WIDTH )
  ) instr_mem (
    .clk       ( clk                                                   ),
    .en_a_i    ( fetch_en                                              ),
    .we_a_i    ( 1'b0                                                  ),
    .be_a_i    ( 4'h0                                                  ),
    .addr_a_i  ( fetch_addr_i[mem_region_pkg::INSTR_ADDR_WIDTH+1:2]    ),
    .wdata_a_i ( 32'h0                                                 ),
    .rdata_a_o ( fetch_rdata_o                                         ),
    .en_b_i    ( load_req_i.req                                        ),
    .we_b_i    ( load_req_i.we                                         ),
    .be_b_i    ( load_req_i.be                                         ),
    .addr_b_i  ( load_req_i.addr[mem_region_pkg::INSTR_ADDR_WIDTH+1:2] ),
    .wdata_b_i ( load_req_i.wdata                                      ),
    .rdata_b_o ( load_rdata_o                                          )
  );

endmodule

`default_nettype wire

/* design/dp_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module dp_ram #(
  parameter int ADDR_WIDTH = 11
) (
  input  wire                   clk,

  input  logic                  en_a_i,
  input  logic                  we_a_i,
  input  logic [3:0]            be_a_i,
  input  logic [ADDR_WIDTH-1:0] addr_a_i,
  input  logic [31:0]           wdata_a_i,
  output logic [31:0]           rdata_a_o,

  input  logic                  en_b_i,
  input  logic                  we_b_i,
  input  logic [3:0]            be_b_i,
  input  logic [ADDR_WIDTH-1:0] addr_b_i,
  input  logic [31:0]           wdata_b_i,
  output logic [31:0]           rdata_b_o
);

  logic [31:0] mem [2**ADDR_WIDTH];

  // Both ports in one process, B wins a same-word write
  always_ff @(posedge clk)
  begin
    if (en_a_i)
    begin
      rdata_a_o <= mem[addr_a_i];  // Old data on a write
      if (we_a_i)
      begin
        for (int i = 0; i < 4; i++)
        begin
          if (be_a_i[i])
            mem[addr_a_i][8*i +: 8] <= wdata_a_i[8*i +: 8];
        end
      end
    end
    if (en_b_i)
    begin
      rdata_b_o <= mem[addr_b_i];
      if (we_b_i)
      begin
        for (int i = 0; i < 4; i++)
        begin
          if (be_b_i[i])
            mem[addr_b_i][8*i +: 8] <= wdata_b_i[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/mem_region_pkg.sv */
`default_nettype none

package mem_region_pkg;

  // Word address widths of the two RAMs
  localparam int INSTR_ADDR_WIDTH = 12;
  localparam int DATA_ADDR_WIDTH  = 11;

  // Region selects on address bits 31:24
  localparam logic [7:0] INSTR_BASE = 8'h1C;
  localparam logic [7:0] DATA_BASE  = 8'h10;

  // Request as driven by the core or an external bus port
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  // Response back towards the requester
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire
